/* compile.f */
+incdir+logic
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/imem_read_stage.sv
logic/branch_predecode.sv
logic/fetch_queue.sv
logic/fetch_top.sv
verif/fetch_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary -j 0 --Mdir build
TOP      = fetch_tb
FILELIST = compile.f
LOG      = run.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides pass or fail
run: build
	./build/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf build $(LOG)

/* verif/fetch_tb.sv */
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_tb;

	import fetch_pkg::*;

	localparam int NUM_PKTS   = 3000;
	localparam int MAX_CYCLES = NUM_PKTS * 8 + 200;
	localparam int HALVES     = `FETCH_IMEM_WORDS * 2;

	logic       clk;
	logic       reset;
	imem_wr_s   imem_wr;
	redirect_s  redirect;
	fetch_pkt_s out_pkt;
	logic       out_valid;
	logic       out_ready;

	// program copy, one entry per 32-bit half, indexed by pc[10:2]
	logic [31:0] prog [0:HALVES-1];

	integer                 seed;
	logic [31:0]            rnd;
	logic [31:0]            rnd_a;
	logic [31:0]            rnd_b;
	logic [`FETCH_XLEN-1:0] exp_pc;
	int                     errs [1:5];
	int                     hits [1:5];
	int                     i;
	int                     accepted;
	int                     cycles;
	int                     upper_cnt;
	int                     lower_cnt;
	int                     back_cnt;
	int                     fwd_cnt;
	int                     redirects;
	int                     total_errs;
	int                     total_hits;
	logic                   after_redirect;
	logic                   prev_jump;
	logic                   hold_prev;
	logic                   redir_prev;
	fetch_pkt_s             held_pkt;

	fetch_top dut (
		.clk       (clk),
		.reset     (reset),
		.imem_wr   (imem_wr),
		.redirect  (redirect),
		.out_pkt   (out_pkt),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// **************************************************
	// program and reference model
	// **************************************************

	// offsets in -512..508, step 4
	function automatic logic [31:0] make_jump(input logic [31:0] sel, input logic [31:0] ofs);
		logic [20:0] off;
		logic [2:0]  f3;
		off = {{11{ofs[9]}}, ofs[9:2], 2'b00};
		f3  = sel[3:1];
		// 010 and 011 are no branch, move them to blt/bge
		if (f3 == 3'b010 || f3 == 3'b011) begin
			f3 = f3 + 3'd2;
		end
		if (sel[0]) begin
			make_jump = {off[20], off[10:1], off[11], off[19:12], sel[11:7], 7'b1101111};
		end
		else begin
			make_jump = {off[12], off[10:5], sel[16:12], sel[21:17], f3, off[4:1], off[11],
				7'b1100011};
		end
	endfunction

	// jal and the six branches, backward taken
	task automatic decode_jump(input logic [31:0] inst, input logic [`FETCH_XLEN-1:0] pc,
		output logic is_jump, output logic taken, output logic [`FETCH_XLEN-1:0] target);
		logic is_b;
		logic is_j;
		is_b = (inst[6:0] == 7'h63) && (inst[14:12] != 3'd2) && (inst[14:12] != 3'd3);
		is_j = (inst[6:0] == 7'h6f);
		is_jump = is_b || is_j;
		taken   = is_jump && inst[31];
		if (is_j) begin
			target = pc + {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
		end
		else begin
			target = pc + {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		end
	endtask

	task automatic report_line(input int n, input string name);
		$display("behavior %0d %s: %0d checks, %0d errors, %s", n, name, hits[n], errs[n],
			(errs[n] == 0) ? "ok" : "mismatch");
	endtask

	// packet that transfers at the coming rising edge
	task automatic check_packet;
		logic [31:0]            exp_inst;
		logic                   exp_jump;
		logic                   exp_taken;
		logic [`FETCH_XLEN-1:0] exp_target;
		int                     b;
		exp_inst = prog[exp_pc[10:2]];
		decode_jump(exp_inst, exp_pc, exp_jump, exp_taken, exp_target);
		// pc check belongs to what led up to this packet
		if (accepted == 0) b = 1;
		else if (after_redirect) b = 5;
		else if (prev_jump) b = 3;
		else b = 2;
		hits[b]++;
		if (out_pkt.pc !== exp_pc) begin
			errs[b]++;
			$display("Fail out_pkt.pc at packet %0d: got 0x%h expected 0x%h", accepted,
				out_pkt.pc, exp_pc);
		end
		hits[2]++;
		if (out_pkt.inst !== exp_inst) begin
			errs[2]++;
			$display("Fail out_pkt.inst at pc 0x%h: got 0x%h expected 0x%h", exp_pc,
				out_pkt.inst, exp_inst);
		end
		hits[3]++;
		if (out_pkt.pred_taken !== exp_taken) begin
			errs[3]++;
			$display("Fail out_pkt.pred_taken at pc 0x%h: got 0x%h expected 0x%h", exp_pc,
				out_pkt.pred_taken, exp_taken);
		end
		if (exp_pc[2]) upper_cnt++;
		else lower_cnt++;
		if (exp_jump && exp_taken) back_cnt++;
		if (exp_jump && !exp_taken) fwd_cnt++;
		// step the model
		exp_pc         = exp_taken ? exp_target : exp_pc + `FETCH_XLEN'd4;
		prev_jump      = exp_jump;
		after_redirect = 1'b0;
		accepted++;
		if (accepted == 1) report_line(1, "reset and first pc");
	endtask

	// **************************************************
	// stimulus
	// **************************************************

	initial begin
		seed      = 32'he778c6c0;
		reset     = 1'b1;
		imem_wr   = '0;
		redirect  = '0;
		out_ready = 1'b0;
		exp_pc    = `FETCH_RESET_PC;
		for (i = 1; i <= 5; i++) begin
			errs[i] = 0;
			hits[i] = 0;
		end
		{accepted, cycles, upper_cnt, lower_cnt, back_cnt, fwd_cnt, redirects} = '0;
		{after_redirect, prev_jump, hold_prev, redir_prev} = '0;
		held_pkt = '0;

		// about a quarter of the halves become jumps
		for (i = 0; i < HALVES; i++) begin
			rnd   = $random(seed);
			rnd_a = $random(seed);
			rnd_b = $random(seed);
			prog[i] = (rnd[1:0] == 2'd0) ? make_jump(rnd_a, rnd_b) : rnd_a;
		end

		// program goes in under reset, then five more reset cycles
		for (i = 0; i < `FETCH_IMEM_WORDS + 6; i++) begin
			@(negedge clk);
			hits[1]++;
			if (out_valid !== 1'b0) begin
				errs[1]++;
				$display("Fail out_valid under reset: got 0x%h expected 0x0", out_valid);
			end
			imem_wr = '0;
			if (i < `FETCH_IMEM_WORDS) begin
				imem_wr.en   = 1'b1;
				imem_wr.addr = i[7:0];
				imem_wr.data = {prog[2*i+1], prog[2*i]};
			end
		end
		reset = 1'b0;

		while (accepted < NUM_PKTS && cycles < MAX_CYCLES) begin
			@(negedge clk);
			cycles++;
			// stalled head must not move or change
			if (hold_prev && !redir_prev) begin
				hits[4]++;
				if (out_valid !== 1'b1) begin
					errs[4]++;
					$display("Fail out_valid under back-pressure: got 0x%h expected 0x1",
						out_valid);
				end
				else if (out_pkt !== held_pkt) begin
					errs[4]++;
					$display("Fail out_pkt under back-pressure: got 0x%h expected 0x%h",
						out_pkt, held_pkt);
				end
			end
			// ~30% back-pressure
			rnd       = $random(seed);
			out_ready = (rnd % 32'd10) >= 32'd3;
			rnd       = $random(seed);
			redirect  = '0;
			// first packet still comes from the reset pc
			if (accepted > 0 && rnd % 32'd40 == 32'd0) begin
				rnd            = $random(seed);
				redirect.valid = 1'b1;
				redirect.pc    = `FETCH_RESET_PC + {53'd0, rnd[8:0], 2'b00};
			end
			if (out_valid && out_ready) check_packet();
			// flush wins over everything behind the head
			if (redirect.valid) begin
				exp_pc         = redirect.pc;
				after_redirect = 1'b1;
				redirects++;
			end
			hold_prev  = out_valid && !out_ready;
			held_pkt   = out_pkt;
			redir_prev = redirect.valid;
		end

		// **************************************************
		// summary
		// **************************************************

		total_errs = 0;
		if (accepted < NUM_PKTS) begin
			total_errs++;
			$display("timeout: only %0d of %0d packets accepted in %0d cycles", accepted,
				NUM_PKTS, cycles);
		end
		if (upper_cnt == 0 || lower_cnt == 0) begin
			errs[2]++;
			$display("sequential fetch never used one of the two memory word halves");
		end
		if (back_cnt == 0 || fwd_cnt == 0) begin
			errs[3]++;
			$display("the stream never held both a backward and a forward jump");
		end
		if (redirects == 0) begin
			errs[5]++;
			$display("no redirect was issued during the run");
		end
		report_line(2, "sequential fetch");
		report_line(3, "static jump prediction");
		report_line(4, "back-pressure");
		report_line(5, "redirect");
		total_hits = 0;
		for (i = 1; i <= 5; i++) begin
			total_errs += errs[i];
			total_hits += hits[i];
		end
		$display("packets %0d, cycles %0d, checks %0d, errors %0d", accepted, cycles,
			total_hits, total_errs);
		if (total_errs == 0) begin
			$display("Verification passed");
		end
		else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_top (
	input  logic                  clk,
	input  logic                  reset,
	input  fetch_pkg::imem_wr_s   imem_wr,
	input  fetch_pkg::redirect_s  redirect,
	output fetch_pkg::fetch_pkt_s out_pkt,
	output logic                  out_valid,
	input  logic                  out_ready
);

	import fetch_pkg::*;

	logic [`FETCH_XLEN-1:0] fetch_pc;
	stage_word_s            stage_word;
	predict_s               predict;
	fetch_pkt_s             pkt;
	logic                   pkt_valid;
	logic                   in_ready;
	logic                   advance;
	logic                   kill;
	logic                   flush;

	// queue room moves the whole front end
	assign advance = in_ready;

	// wrong-path word only dies when the jump itself moves on
	assign kill  = predict.taken & advance;
	assign flush = redirect.valid;

	// **************************************************
	// stages
	// **************************************************

	pc_gen u_pc_gen (
		.clk      (clk),
		.reset    (reset),
		.redirect (redirect),
		.advance  (advance),
		.predict  (predict),
		.fetch_pc (fetch_pc)
	);

	imem_read_stage u_imem_read_stage (
		.clk            (clk),
		.reset          (reset),
		.fetch_pc       (fetch_pc),
		.advance        (advance),
		.redirect_valid (redirect.valid),
		.kill           (kill),
		.imem_wr        (imem_wr),
		.word           (stage_word)
	);

	branch_predecode u_branch_predecode (
		.word      (stage_word),
		.predict   (predict),
		.pkt       (pkt),
		.pkt_valid (pkt_valid)
	);

	fetch_queue u_fetch_queue (
		.clk       (clk),
		.reset     (reset),
		.flush     (flush),
		.in_pkt    (pkt),
		.in_valid  (pkt_valid),
		.in_ready  (in_ready),
		.out_pkt   (out_pkt),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

/* logic/fetch_queue.sv */
`timescale 1ns/100ps

module fetch_queue (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  flush,
	input  fetch_pkg::fetch_pkt_s in_pkt,
	input  logic                  in_valid,
	output logic                  in_ready,
	output fetch_pkg::fetch_pkt_s out_pkt,
	output logic                  out_valid,
	input  logic                  out_ready
);

	import fetch_pkg::*;

	// two packet slots
	fetch_pkt_s slot [0:1];

	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;
	logic       push;
	logic       pop;

	// **************************************************
	// handshake
	// **************************************************

	// room for one more
	assign in_ready  = (count < 2'd2);
	assign out_valid = (count != 2'd0);
	assign out_pkt   = slot[rd_ptr];

	assign push = in_valid & in_ready;
	assign pop  = out_valid & out_ready;

	// payload slots
	always_ff @(posedge clk) begin
		if (push) begin
			slot[wr_ptr] <= in_pkt;
		end
	end

	// **************************************************
	// pointers and count
	// **************************************************

	// flush drops anything pushed in the same clock
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end
		else begin
			if (push) begin
				wr_ptr <= ~wr_ptr;
			end
			if (pop) begin
				rd_ptr <= ~rd_ptr;
			end
			// push and pop together keep the count
			case ({push, pop})
				2'b10:   count <= count + 2'd1;
				2'b01:   count <= count - 2'd1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* logic/branch_predecode.sv */
`timescale 1ns/100ps
`include "fetch_params.svh"

module branch_predecode (
	input  fetch_pkg::stage_word_s word,
	output fetch_pkg::predict_s    predict,
	output fetch_pkg::fetch_pkt_s  pkt,
	output logic                   pkt_valid
);

	import fetch_pkg::*;

	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	rv_inst_u               inst_u;
	logic                   is_jal;
	logic                   is_branch;
	logic                   is_jump;
	logic                   backward;
	logic [`FETCH_XLEN-1:0] imm_b;
	logic [`FETCH_XLEN-1:0] imm_j;
	logic [`FETCH_XLEN-1:0] imm_sel;

	assign inst_u = word.inst;

	// **************************************************
	// jump recognition
	// **************************************************

	assign is_jal = (inst_u.j.opcode == OP_JAL);

	// beq bne blt bge bltu bgeu
	// 010 and 011 are not branches
	always_comb begin
		is_branch = 1'b0;
		if (inst_u.b.opcode == OP_BRANCH) begin
			case (inst_u.b.funct3)
				3'b000:  is_branch = 1'b1;
				3'b001:  is_branch = 1'b1;
				3'b100:  is_branch = 1'b1;
				3'b101:  is_branch = 1'b1;
				3'b110:  is_branch = 1'b1;
				3'b111:  is_branch = 1'b1;
				default: is_branch = 1'b0;
			endcase
		end
	end

	assign is_jump = is_jal | is_branch;

	// **************************************************
	// immediates
	// **************************************************

	// 13-bit B offset, sign extended
	assign imm_b = {{(`FETCH_XLEN-13){inst_u.b.sign}}, inst_u.b.sign, inst_u.b.imm_11,
		inst_u.b.imm_10_5, inst_u.b.imm_4_1, 1'b0};

	// 21-bit J offset, sign extended
	assign imm_j = {{(`FETCH_XLEN-21){inst_u.j.sign}}, inst_u.j.sign, inst_u.j.imm_19_12,
		inst_u.j.imm_11, inst_u.j.imm_10_1, 1'b0};

	assign imm_sel = is_jal ? imm_j : imm_b;

	// sign bit sits at 31 in both views
	assign backward = inst_u.b.sign;

	// static rule, backward taken
	// nothing predicted from an empty stage
	assign predict.taken  = word.valid & is_jump & backward;
	assign predict.target = word.pc + imm_sel;

	// packet toward the queue
	assign pkt.pc         = word.pc;
	assign pkt.inst       = word.inst;
	assign pkt.pred_taken = predict.taken;
	assign pkt_valid      = word.valid;

endmodule

/* logic/imem_read_stage.sv */
`timescale 1ns/100ps
`include "fetch_params.svh"

module imem_read_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`FETCH_XLEN-1:0] fetch_pc,
	input  logic                   advance,
	input  logic                   redirect_valid,
	input  logic                   kill,
	input  fetch_pkg::imem_wr_s    imem_wr,
	output fetch_pkg::stage_word_s word
);

	localparam int IDX_W = $clog2(`FETCH_IMEM_WORDS);

	// 64-bit words, two instructions each
	logic [`FETCH_XLEN-1:0] mem [0:`FETCH_IMEM_WORDS-1];

	logic [IDX_W-1:0]       rd_idx;
	logic [`FETCH_XLEN-1:0] rd_word;

	logic                   valid_q;
	logic [`FETCH_XLEN-1:0] pc_q;
	logic [31:0]            inst_q;

	// word index, wraps over the depth
	assign rd_idx  = fetch_pc[3 +: IDX_W];
	assign rd_word = mem[rd_idx];

	// loader port
	always_ff @(posedge clk) begin
		if (imem_wr.en) begin
			mem[imem_wr.addr] <= imem_wr.data;
		end
	end

	// **************************************************
	// second stage register
	// **************************************************

	// pc bit 2 picks the upper half
	always_ff @(posedge clk) begin
		if (advance) begin
			pc_q   <= fetch_pc;
			inst_q <= fetch_pc[2] ? rd_word[63:32] : rd_word[31:0];
		end
	end

	// kill drops the one wrong-path word behind a taken jump
	always_ff @(posedge clk) begin
		if (reset || redirect_valid || kill) begin
			valid_q <= 1'b0;
		end
		else if (advance) begin
			valid_q <= 1'b1;
		end
	end

	assign word = '{valid: valid_q, pc: pc_q, inst: inst_q};

endmodule

/* logic/pc_gen.sv */
`timescale 1ns/100ps
`include "fetch_params.svh"

module pc_gen (
	input  logic                   clk,
	input  logic                   reset,
	input  fetch_pkg::redirect_s   redirect,
	input  logic                   advance,
	input  fetch_pkg::predict_s    predict,
	output logic [`FETCH_XLEN-1:0] fetch_pc
);

	// **************************************************
	// next pc select
	// **************************************************

	logic [`FETCH_XLEN-1:0] pc_plus4;
	logic [`FETCH_XLEN-1:0] pc_next;
	logic                   pc_en;

	// sequential fetch
	assign pc_plus4 = fetch_pc + `FETCH_XLEN'd4;

	// redirect sits ahead of the stall
	// so a restart is never lost while decode is full
	always_comb begin
		if (redirect.valid) begin
			// back end restart
			pc_next = redirect.pc;
			pc_en   = 1'b1;
		end
		else if (!advance) begin
			// queue full, hold
			pc_next = fetch_pc;
			pc_en   = 1'b0;
		end
		else if (predict.taken) begin
			// backward jump in the stage
			pc_next = predict.target;
			pc_en   = 1'b1;
		end
		else begin
			pc_next = pc_plus4;
			pc_en   = 1'b1;
		end
	end

	// **************************************************
	// pc register
	// **************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_pc <= `FETCH_RESET_PC;
		end
		else if (pc_en) begin
			fetch_pc <= pc_next;
		end
	end

endmodule

/* logic/fetch_pkg.sv */
`include "fetch_params.svh"

package fetch_pkg;

	// **************************************************
	// packets between the stages
	// **************************************************

	// one fetched instruction toward decode
	typedef struct packed {
		logic [`FETCH_XLEN-1:0] pc;
		logic [31:0]            inst;
		logic                   pred_taken;
	} fetch_pkt_s;

	// registered output of the memory stage
	typedef struct packed {
		logic                   valid;
		logic [`FETCH_XLEN-1:0] pc;
		logic [31:0]            inst;
	} stage_word_s;

	// static prediction back to pc select
	typedef struct packed {
		logic                   taken;
		logic [`FETCH_XLEN-1:0] target;
	} predict_s;

	// back end restart, one cycle pulse
	typedef struct packed {
		logic                   valid;
		logic [`FETCH_XLEN-1:0] pc;
	} redirect_s;

	// loader write into the instruction memory
	typedef struct packed {
		logic                                 en;
		logic [$clog2(`FETCH_IMEM_WORDS)-1:0] addr;
		logic [`FETCH_XLEN-1:0]               data;
	} imem_wr_s;

	// **************************************************
	// instruction views
	// **************************************************

	// conditional branch layout
	typedef struct packed {
		logic       sign;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_s;

	// jal layout
	typedef struct packed {
		logic       sign;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_s;

	// same 32-bit word, read either way
	typedef union packed {
		b_fmt_s b;
		j_fmt_s j;
	} rv_inst_u;

endpackage

/* logic/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// pc, address and memory word width
`define FETCH_XLEN 64

// first fetch address out of reset
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// number of 64-bit words in the instruction memory
// pc bits above bit 2 index it, wrapping over the depth
`define FETCH_IMEM_WORDS 256

`endif
